//--- design/taint_mul_defs.svh
// ================================================
// Taint multiplier widths
// Operand width and the widths derived from it
// ================================================

`ifndef TAINT_MUL_DEFS_SVH
`define TAINT_MUL_DEFS_SVH

// Operand width in bits
`define MUL_WIDTH 8

// Full product
`define MUL_PROD_WIDTH (2 * `MUL_WIDTH)

// Product plus one carry bit for the running sum
`define MUL_ACC_WIDTH (`MUL_PROD_WIDTH + 1)

// Bit counter has to reach MUL_WIDTH itself
`define MUL_CNT_WIDTH ($clog2(`MUL_WIDTH + 1))

`endif

//--- design/taint_mul_pkg.sv
// ================================================
// Taint multiplier types
// Control strobes, operands and accumulator word
// ================================================

`include "taint_mul_defs.svh"

package taint_mul_pkg;

    // Register strobes from the controller
    // Same layout carries the strobe taint
    typedef struct packed {
        logic mdld;
        logic mrld;
        logic rsclear;
        logic rsload;
        logic rsshr;
    } mul_ctl_t;

    // Operand value with its taint word
    typedef struct packed {
        logic [`MUL_WIDTH-1:0] value;
        logic [`MUL_WIDTH-1:0] taint;
    } mul_operand_t;

    // Running sum split into carry, upper and lower halves
    typedef struct packed {
        logic                  carry;
        logic [`MUL_WIDTH-1:0] hi;
        logic [`MUL_WIDTH-1:0] lo;
    } mul_acc_parts_t;

    // Whole word for add and shift, parts for the product
    typedef union packed {
        logic [`MUL_ACC_WIDTH-1:0] full;
        mul_acc_parts_t            parts;
    } mul_acc_u;

endpackage

//--- design/taint_mul_datapath.sv
// ================================================
// Taint multiplier datapath
// Shift-add registers with taint shadow registers
// ================================================

`include "taint_mul_defs.svh"

module taint_mul_datapath import taint_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mul_operand_t          multiplicand,
    input  mul_operand_t          multiplier,
    input  mul_ctl_t              ctl,
    input  mul_ctl_t              ctl_t,
    output logic [`MUL_WIDTH-1:0] multiplier_reg,
    output logic [`MUL_WIDTH-1:0] multiplier_reg_t,
    output mul_acc_u              sum,
    output mul_acc_u              sum_t
);

    localparam logic [`MUL_CNT_WIDTH-1:0] STEPS     = `MUL_WIDTH;
    localparam logic [`MUL_CNT_WIDTH-1:0] LAST_STEP = `MUL_WIDTH - 1;

    // Multiplicand sits in the upper half of the accumulator
    logic [`MUL_ACC_WIDTH-1:0] md_reg;
    logic [`MUL_ACC_WIDTH-1:0] md_reg_t;

    // Adder result, its taint and carry into each bit
    logic [`MUL_ACC_WIDTH-1:0] add_sum;
    logic [`MUL_ACC_WIDTH-1:0] add_t;
    logic [`MUL_ACC_WIDTH-1:0] carry;

    // Shift tracking for the final carry check
    logic [`MUL_CNT_WIDTH-1:0] shr_cnt;
    logic                      chk_due;

    // ================================================
    // Adder with carry-driven taint
    // ================================================

    always_comb begin
        carry[0] = 1'b0;
        for (int i = 0; i < `MUL_ACC_WIDTH - 1; i++) begin
            carry[i+1] = (md_reg[i] & sum.full[i]) |
                         (md_reg[i] & carry[i]) |
                         (sum.full[i] & carry[i]);
        end
        add_sum = md_reg ^ sum.full ^ carry;

        // Tainted input bit that carries out taints the bit above
        add_t = md_reg_t | sum_t.full;
        for (int i = 0; i < `MUL_ACC_WIDTH - 1; i++) begin
            if (carry[i+1] && (md_reg_t[i] || sum_t.full[i])) begin
                add_t[i+1] = 1'b1;
            end
        end
    end

    // ================================================
    // Data registers
    // ================================================

    always_ff @(posedge clk) begin
        if (ctl.mdld) begin
            md_reg <= {1'b0, multiplicand.value, {`MUL_WIDTH{1'b0}}};
        end

        if (ctl.mrld) begin
            multiplier_reg <= multiplier.value;
        end

        // Strobes on the sum are exclusive by construction
        if (ctl.rsclear) begin
            sum.full <= '0;
        end else if (ctl.rsload) begin
            sum.full <= add_sum;
        end else if (ctl.rsshr) begin
            sum.full <= sum.full >> 1;
        end
    end

    // ================================================
    // Taint shadows
    // ================================================

    // A tainted strobe, high or low, leaves the target fully tainted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            md_reg_t         <= '0;
            multiplier_reg_t <= '0;
            sum_t.full       <= '0;
        end else begin
            if (ctl_t.mdld) begin
                md_reg_t <= '1;
            end else if (ctl.mdld) begin
                md_reg_t <= {1'b0, multiplicand.taint, {`MUL_WIDTH{1'b0}}};
            end

            if (ctl_t.mrld) begin
                multiplier_reg_t <= '1;
            end else if (ctl.mrld) begin
                multiplier_reg_t <= multiplier.taint;
            end

            if (ctl_t.rsclear || ctl_t.rsload || ctl_t.rsshr) begin
                sum_t.full <= '1;
            end else if (ctl.rsclear) begin
                sum_t.full <= '0;
            end else if (ctl.rsload) begin
                sum_t.full <= add_t;
            end else if (ctl.rsshr) begin
                // Zero taint enters at the top with the zero value
                sum_t.full <= sum_t.full >> 1;
            end
        end
    end

    // ================================================
    // Final carry check
    // ================================================

    // Counter parks at STEPS until a load starts an operation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shr_cnt <= STEPS;
            chk_due <= 1'b0;
        end else begin
            chk_due <= ctl.rsshr && (shr_cnt == LAST_STEP);
            if (ctl.mdld) begin
                shr_cnt <= '0;
            end else if (ctl.rsshr && (shr_cnt != STEPS)) begin
                shr_cnt <= shr_cnt + 1'b1;
            end
        end
    end

    // Product fits in hi and lo once all shifts are done
    a_carry_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_due |-> (sum.parts.carry == 1'b0)
    ) else $error("Carry bit set after the last shift");

endmodule

//--- design/taint_mul_controller.sv
// ================================================
// Taint multiplier controller
// Walks multiplier bits and issues tainted strobes
// ================================================

`include "taint_mul_defs.svh"

module taint_mul_controller import taint_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  start_t,
    input  logic [`MUL_WIDTH-1:0] multiplier_reg,
    input  logic [`MUL_WIDTH-1:0] multiplier_reg_t,
    output mul_ctl_t              ctl,
    output mul_ctl_t              ctl_t,
    output logic                  busy,
    output logic                  done
);

    localparam logic [`MUL_CNT_WIDTH-1:0] LAST_STEP = `MUL_WIDTH - 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_ADD,
        S_SHIFT,
        S_DONE
    } state_t;

    state_t                    state;
    state_t                    state_nxt;
    logic [`MUL_CNT_WIDTH-1:0] cnt;
    logic                      op_t;
    logic                      bit_k;
    logic                      bit_k_t;

    // Multiplier bit for the current step
    assign bit_k   = multiplier_reg[cnt[$clog2(`MUL_WIDTH)-1:0]];
    assign bit_k_t = multiplier_reg_t[cnt[$clog2(`MUL_WIDTH)-1:0]];

    // ================================================
    // State machine
    // ================================================

    // LOAD is the first cycle after the start edge, DONE the 2W+2th
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD:  state_nxt = S_ADD;
            S_ADD:   state_nxt = S_SHIFT;
            S_SHIFT: state_nxt = (cnt == LAST_STEP) ? S_DONE : S_ADD;
            S_DONE:  state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
            op_t  <= 1'b0;
        end else begin
            state <= state_nxt;

            // Operation taint is fixed by the start that opened it
            if (state == S_IDLE && start) begin
                op_t <= start_t;
            end

            // Step counter ends at MUL_WIDTH on entering DONE
            if (state == S_LOAD) begin
                cnt <= '0;
            end else if (state == S_SHIFT) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // ================================================
    // Strobes and their taint
    // ================================================

    always_comb begin
        ctl   = '0;
        ctl_t = '0;
        case (state)
            S_LOAD: begin
                ctl.mdld      = 1'b1;
                ctl.mrld      = 1'b1;
                ctl.rsclear   = 1'b1;
                ctl_t.mdld    = op_t;
                ctl_t.mrld    = op_t;
                ctl_t.rsclear = op_t;
            end
            S_ADD: begin
                // Add decision follows the multiplier bit, so does its taint
                ctl.rsload   = bit_k;
                ctl_t.rsload = bit_k_t | op_t;
            end
            S_SHIFT: begin
                ctl.rsshr   = 1'b1;
                ctl_t.rsshr = op_t;
            end
            default: ;
        endcase
    end

    assign busy = (state != S_IDLE);
    assign done = (state == S_DONE);

    // ================================================
    // Assertions
    // ================================================

    a_add_shift_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctl.rsload && ctl.rsshr)
    ) else $error("Add and shift strobes high together");

    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= `MUL_WIDTH
    ) else $error("Step counter past the operand width");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("Done held longer than one cycle");

endmodule

//--- design/taint_mul_top.sv
// ================================================
// Taint-tracking shift-add multiplier
// Controller and datapath with product outputs
// ================================================

`include "taint_mul_defs.svh"

module taint_mul_top import taint_mul_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       start_t,
    input  mul_operand_t               multiplicand,
    input  mul_operand_t               multiplier,
    output logic [`MUL_PROD_WIDTH-1:0] product,
    output logic [`MUL_PROD_WIDTH-1:0] product_t,
    output logic                       busy,
    output logic                       done
);

    mul_ctl_t              ctl;
    mul_ctl_t              ctl_t;
    logic [`MUL_WIDTH-1:0] multiplier_reg;
    logic [`MUL_WIDTH-1:0] multiplier_reg_t;
    mul_acc_u              sum;
    mul_acc_u              sum_t;

    taint_mul_controller i_taint_mul_controller (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .start_t          (start_t),
        .multiplier_reg   (multiplier_reg),
        .multiplier_reg_t (multiplier_reg_t),
        .ctl              (ctl),
        .ctl_t            (ctl_t),
        .busy             (busy),
        .done             (done)
    );

    taint_mul_datapath i_taint_mul_datapath (
        .clk              (clk),
        .rst_n            (rst_n),
        .multiplicand     (multiplicand),
        .multiplier       (multiplier),
        .ctl              (ctl),
        .ctl_t            (ctl_t),
        .multiplier_reg   (multiplier_reg),
        .multiplier_reg_t (multiplier_reg_t),
        .sum              (sum),
        .sum_t            (sum_t)
    );

    // Product drops the carry bit of the running sum
    assign product   = {sum.parts.hi, sum.parts.lo};
    assign product_t = {sum_t.parts.hi, sum_t.parts.lo};

endmodule

//--- test/taint_mul_tb.sv
// ================================================
// Taint multiplier testbench
// Directed table and seeded random rows vs a model
// ================================================

`include "taint_mul_defs.svh"

module taint_mul_tb import taint_mul_pkg::*; ();

    localparam int W         = `MUL_WIDTH;
    localparam int PROD_W    = `MUL_PROD_WIDTH;
    localparam int ACC_W     = `MUL_ACC_WIDTH;
    localparam int DRIVE_DLY = 1;
    // LOAD counts as cycle 1, then two cycles per bit, then DONE
    localparam int LATENCY   = 2 * W + 2;
    localparam int N_DIR     = 11;
    localparam int N_RAND    = 40;
    localparam int TIMEOUT_CYCLES = (N_DIR + N_RAND) * 20 + 100;
    localparam logic [31:0] RAND_SEED = 32'h8ca5_64fb;

    // One directed row of operands, start taint, restart flag and expected results
    typedef struct packed {
        mul_operand_t        md;
        mul_operand_t        mr;
        logic                st_t;
        logic                restart;
        logic [PROD_W-1:0]   exp_p;
        logic [PROD_W-1:0]   exp_t;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                start_t;
    mul_operand_t        multiplicand;
    mul_operand_t        multiplier;
    logic [PROD_W-1:0]   product;
    logic [PROD_W-1:0]   product_t;
    logic                busy;
    logic                done;

    row_t                rows [N_DIR];
    int                  cycle_count;

    taint_mul_top i_taint_mul_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .start_t      (start_t),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .product_t    (product_t),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ================================================
    // Failure reporting and checks
    // ================================================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("The run went past its cycle limit without finishing");
        end
    end

    // ================================================
    // Reference model
    // ================================================

    // Taint of a + b where carry out of a tainted bit taints the bit above
    function automatic logic [ACC_W-1:0] add_taint(input logic [ACC_W-1:0] a,
                                                   input logic [ACC_W-1:0] a_t,
                                                   input logic [ACC_W-1:0] b,
                                                   input logic [ACC_W-1:0] b_t);
        logic [ACC_W:0]   mask;
        logic [ACC_W:0]   part;
        logic [ACC_W-1:0] t;
        t = a_t | b_t;
        for (int i = 0; i < ACC_W - 1; i++) begin
            // Bit i+1 of the low i+1 bits summed alone is the carry out of bit i
            mask = ({{ACC_W{1'b0}}, 1'b1} << (i + 1)) - 1'b1;
            part = ({1'b0, a} & mask) + ({1'b0, b} & mask);
            if (part[i + 1] && (a_t[i] || b_t[i])) begin
                t[i + 1] = 1'b1;
            end
        end
        return t;
    endfunction

    // Returns product in the upper half and product taint in the lower half
    function automatic logic [2*PROD_W-1:0] model_mul(input mul_operand_t md,
                                                      input mul_operand_t mr,
                                                      input logic op_t);
        logic [ACC_W-1:0]  acc;
        logic [ACC_W-1:0]  acc_t;
        logic [ACC_W-1:0]  addend;
        logic [ACC_W-1:0]  addend_t;
        logic [PROD_W-1:0] prod;
        acc      = '0;
        acc_t    = op_t ? '1 : '0;
        addend   = {1'b0, md.value, {W{1'b0}}};
        addend_t = op_t ? '1 : {1'b0, md.taint, {W{1'b0}}};
        for (int k = 0; k < W; k++) begin
            if (op_t || mr.taint[k]) begin
                acc_t = '1;
            end else if (mr.value[k]) begin
                acc_t = add_taint(acc, acc_t, addend, addend_t);
            end
            if (mr.value[k]) begin
                acc = acc + addend;
            end
            acc   = acc >> 1;
            acc_t = op_t ? '1 : (acc_t >> 1);
        end
        prod = md.value * mr.value;
        return {prod, acc_t[PROD_W-1:0]};
    endfunction

    // ================================================
    // Stimulus
    // ================================================

    task automatic run_op(input mul_operand_t md, input mul_operand_t mr, input logic st_t,
                          input logic restart, input logic [PROD_W-1:0] exp_p,
                          input logic [PROD_W-1:0] exp_t);
        int cyc;
        multiplicand = md;
        multiplier   = mr;
        start_t      = st_t;
        start        = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start   = 1'b0;
        start_t = 1'b0;
        cyc     = 1;
        while (done !== 1'b1) begin
            check_value("busy", busy, 1'b1);
            if (cyc > LATENCY) begin
                fail_run("Done did not arrive within the expected latency");
            end
            // Tainted second start mid-operation with other operands
            if (restart && cyc == 5) begin
                start        = 1'b1;
                start_t      = 1'b1;
                multiplicand = ~md;
                multiplier   = ~mr;
            end
            if (restart && cyc == 6) begin
                start   = 1'b0;
                start_t = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DLY;
            cyc++;
        end
        check_value("done_latency", cyc, LATENCY);
        check_value("busy", busy, 1'b1);
        check_value("product", product, exp_p);
        check_value("product_t", product_t, exp_t);
        @(posedge clk);
        #DRIVE_DLY;
        check_value("done", done, 1'b0);
        check_value("busy", busy, 1'b0);
    endtask

    // Expected values follow the shift-add and taint rules by hand
    task automatic fill_table();
        // Untainted products
        rows[0]  = '{'{8'h00, 8'h00}, '{8'h5a, 8'h00}, 1'b0, 1'b0, 16'h0000, 16'h0000};
        rows[1]  = '{'{8'hff, 8'h00}, '{8'hff, 8'h00}, 1'b0, 1'b0, 16'hfe01, 16'h0000};
        rows[2]  = '{'{8'h01, 8'h00}, '{8'hc3, 8'h00}, 1'b0, 1'b0, 16'h00c3, 16'h0000};
        rows[3]  = '{'{8'h0d, 8'h00}, '{8'h0b, 8'h00}, 1'b0, 1'b0, 16'h008f, 16'h0000};
        // Tainted multiplier bit floods the sum and later shifts drain the top
        rows[4]  = '{'{8'h03, 8'h00}, '{8'h01, 8'h01}, 1'b0, 1'b0, 16'h0003, 16'h01ff};
        rows[5]  = '{'{8'h05, 8'h00}, '{8'h09, 8'h08}, 1'b0, 1'b0, 16'h002d, 16'h0fff};
        // Multiplicand taint with and without carries
        rows[6]  = '{'{8'h0f, 8'h01}, '{8'h03, 8'h00}, 1'b0, 1'b0, 16'h002d, 16'h0007};
        rows[7]  = '{'{8'h11, 8'h01}, '{8'h05, 8'h00}, 1'b0, 1'b0, 16'h0055, 16'h0005};
        // Tainted start followed by a clean repeat
        rows[8]  = '{'{8'h12, 8'h3c}, '{8'h34, 8'ha5}, 1'b1, 1'b0, 16'h03a8, 16'hffff};
        rows[9]  = '{'{8'h12, 8'h00}, '{8'h34, 8'h00}, 1'b0, 1'b0, 16'h03a8, 16'h0000};
        // Start while busy is ignored
        rows[10] = '{'{8'h0d, 8'h00}, '{8'h0b, 8'h00}, 1'b0, 1'b1, 16'h008f, 16'h0000};
    endtask

    initial begin
        mul_operand_t        md;
        mul_operand_t        mr;
        logic                st_t;
        logic [2*PROD_W-1:0] expected;
        rst_n        = 1'b0;
        start        = 1'b0;
        start_t      = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        void'($urandom(RAND_SEED));
        fill_table();

        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);

        for (int n = 0; n < N_DIR; n++) begin
            run_op(rows[n].md, rows[n].mr, rows[n].st_t, rows[n].restart,
                   rows[n].exp_p, rows[n].exp_t);
        end

        // Sparse taint so carry spreading stays visible
        for (int n = 0; n < N_RAND; n++) begin
            md.value = W'($urandom);
            md.taint = W'($urandom & $urandom & $urandom);
            mr.value = W'($urandom);
            mr.taint = W'($urandom & $urandom & $urandom & $urandom);
            st_t     = (($urandom % 8) == 0);
            expected = model_mul(md, mr, st_t);
            run_op(md, mr, st_t, 1'b0, expected[2*PROD_W-1:PROD_W], expected[PROD_W-1:0]);
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- taint_mul_top.f
+incdir+design
design/taint_mul_pkg.sv
design/taint_mul_datapath.sv
design/taint_mul_controller.sv
design/taint_mul_top.sv
test/taint_mul_tb.sv

//--- Bender.yml
package:
  name: taint_mul

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/taint_mul_pkg.sv
      - design/taint_mul_datapath.sv
      - design/taint_mul_controller.sv
      - design/taint_mul_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/taint_mul_tb.sv
